/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] xlen_t;
   typedef logic [4:0]      reg_idx_t;

   // Major opcodes
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_AUIPC  = 7'b0010111;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_REG    = 7'b0110011;

   ////////////////////////////////////////////////////////////
   // Instruction formats
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      reg_idx_t   rd;
      logic [6:0] opcode;
   } j_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      b_fmt_t b;
      u_fmt_t u;
      j_fmt_t j;
   } instr_u;

   // Compare ops return 0 or 1 in bit 0
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
      ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
   } alu_op_t;

   typedef enum logic [1:0] {MEM_NOP, MEM_LW, MEM_SW} mem_op_t;

   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wb_sel_t;

   typedef enum logic [3:0] {
      PC_FETCH, INST_DEC, READ_REGS, ALU_START, WAIT_ALU,
      MEM_OP, WRITEBACK, CALC_NEXT_PC, WAIT_ALU_PC, STORE_ALU_PC
   } stage_t;

endpackage

`default_nettype wire

/* instr_decoder.sv */
`default_nettype none

module instr_decoder import rv_pkg::*; (
   input  wire logic   clk,
   input  wire logic   store_i,
   input  wire xlen_t  raw_i,
   output instr_u      instr_o,
   output xlen_t       imm_o,
   output xlen_t       imm_next_o
);

   instr_u word;

   assign word = raw_i;

   ////////////////////////////////////////////////////////////
   // Immediate generation
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (word.r.opcode)
         OP_LUI, OP_AUIPC: begin
            imm_next_o = {word.u.imm, 12'b0};
         end
         OP_JAL: begin
            imm_next_o = {{12{word.j.imm20}}, word.j.imm19_12, word.j.imm11,
                          word.j.imm10_1, 1'b0};
         end
         OP_BRANCH: begin
            imm_next_o = {{20{word.b.imm12}}, word.b.imm11, word.b.imm10_5,
                          word.b.imm4_1, 1'b0};
         end
         OP_STORE: begin
            imm_next_o = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
         end
         // I format for loads, JALR and OP-IMM
         default: begin
            imm_next_o = {{20{word.i.imm[11]}}, word.i.imm};
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (store_i) begin
         instr_o <= word;
         imm_o   <= imm_next_o;
      end
   end

endmodule

`default_nettype wire

/* control_unit.sv */
`default_nettype none

module control_unit import rv_pkg::*; (
   input  wire logic   clk,
   input  wire logic   decode_i,
   input  wire instr_u instr_i,
   output reg_idx_t    rs1_o,
   output reg_idx_t    rs2_o,
   output reg_idx_t    rd_o,
   output alu_op_t     alu_op_o,
   output logic        alu_from_pc_o,
   output logic        alu_from_imm_o,
   output logic        reg_write_o,
   output wb_sel_t     wb_sel_o,
   output mem_op_t     mem_op_o,
   output logic        is_jal_o,
   output logic        is_jalr_o,
   output logic        is_branch_o,
   output logic        invalid_o
);

   alu_op_t    alu_op;
   logic       from_pc;
   logic       from_imm;
   logic       reg_write;
   wb_sel_t    wb_sel;
   mem_op_t    mem_op;
   logic       is_jal;
   logic       is_jalr;
   logic       is_branch;
   logic       invalid;
   logic [2:0] f3;
   logic       alt;
   logic       is_reg;

   assign f3     = instr_i.r.funct3;
   assign alt    = (instr_i.r.funct7 == 7'b0100000);
   assign is_reg = (instr_i.r.opcode == OP_REG);

   always_comb begin
      alu_op    = ALU_ADD;
      from_pc   = 1'b0;
      from_imm  = 1'b0;
      reg_write = 1'b0;
      wb_sel    = WB_ALU;
      mem_op    = MEM_NOP;
      is_jal    = 1'b0;
      is_jalr   = 1'b0;
      is_branch = 1'b0;
      invalid   = 1'b0;
      case (instr_i.r.opcode)
         OP_LUI: begin
            reg_write = 1'b1;
            wb_sel    = WB_IMM;
         end
         OP_AUIPC: begin
            from_pc   = 1'b1;
            from_imm  = 1'b1;
            reg_write = 1'b1;
         end
         OP_JAL: begin
            from_pc   = 1'b1;
            from_imm  = 1'b1;
            reg_write = 1'b1;
            wb_sel    = WB_PC4;
            is_jal    = 1'b1;
         end
         OP_JALR: begin
            from_imm  = 1'b1;
            reg_write = 1'b1;
            wb_sel    = WB_PC4;
            is_jalr   = 1'b1;
            invalid   = (f3 != 3'b000);
         end
         OP_BRANCH: begin
            is_branch = 1'b1;
            case (f3)
               3'b000:  alu_op = ALU_EQ;
               3'b001:  alu_op = ALU_NE;
               3'b100:  alu_op = ALU_LT;
               3'b101:  alu_op = ALU_GE;
               3'b110:  alu_op = ALU_LTU;
               3'b111:  alu_op = ALU_GEU;
               default: invalid = 1'b1;
            endcase
         end
         OP_LOAD: begin
            from_imm  = 1'b1;
            reg_write = 1'b1;
            wb_sel    = WB_MEM;
            mem_op    = MEM_LW;
            invalid   = (f3 != 3'b010);
         end
         OP_STORE: begin
            from_imm = 1'b1;
            mem_op   = MEM_SW;
            invalid  = (f3 != 3'b010);
         end
         OP_IMM, OP_REG: begin
            from_imm  = !is_reg;
            reg_write = 1'b1;
            unique case (f3)
               3'b000: alu_op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
               3'b001: alu_op = ALU_SLL;
               3'b010: alu_op = ALU_SLT;
               3'b011: alu_op = ALU_SLTU;
               3'b100: alu_op = ALU_XOR;
               3'b101: alu_op = alt ? ALU_SRA : ALU_SRL;
               3'b110: alu_op = ALU_OR;
               3'b111: alu_op = ALU_AND;
            endcase
            // funct7 only decoded for register ops and immediate shifts
            if ((is_reg || f3 == 3'b001 || f3 == 3'b101) &&
                instr_i.r.funct7 != 7'b0 &&
                !(alt && (f3 == 3'b101 || (is_reg && f3 == 3'b000)))) begin
               invalid = 1'b1;
            end
         end
         default: invalid = 1'b1;
      endcase
      if (invalid) begin
         reg_write = 1'b0;
         mem_op    = MEM_NOP;
      end
   end

   always_ff @(posedge clk) begin
      if (decode_i) begin
         rs1_o          <= instr_i.r.rs1;
         rs2_o          <= instr_i.r.rs2;
         rd_o           <= instr_i.r.rd;
         alu_op_o       <= alu_op;
         alu_from_pc_o  <= from_pc;
         alu_from_imm_o <= from_imm;
         reg_write_o    <= reg_write;
         wb_sel_o       <= wb_sel;
         mem_op_o       <= mem_op;
         is_jal_o       <= is_jal;
         is_jalr_o      <= is_jalr;
         is_branch_o    <= is_branch;
         invalid_o      <= invalid;
      end
   end

endmodule

`default_nettype wire

/* reg_file.sv */
`default_nettype none

module reg_file import rv_pkg::*; (
   input  wire logic     clk,
   input  wire reg_idx_t rs1_i,
   input  wire reg_idx_t rs2_i,
   input  wire reg_idx_t rd_i,
   input  wire logic     we_i,
   input  wire xlen_t    wdata_i,
   output xlen_t         rdata1_o,
   output xlen_t         rdata2_o
);

   // x0 has no storage
   xlen_t regs [1:31];

   assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
   assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

   always_ff @(posedge clk) begin
      if (we_i && rd_i != 5'd0) begin
         regs[rd_i] <= wdata_i;
      end
   end

endmodule

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu import rv_pkg::*; (
   input  wire logic    clk,
   input  wire logic    rst,
   input  wire logic    start_i,
   input  wire alu_op_t op_i,
   input  wire xlen_t   a_i,
   input  wire xlen_t   b_i,
   output logic         done_o,
   output xlen_t        result_o
);

   xlen_t      comb_result;
   xlen_t      shifted;
   alu_op_t    shift_op;
   logic [4:0] count;
   logic       busy;
   logic       is_shift;

   assign is_shift = (op_i == ALU_SLL) || (op_i == ALU_SRL) || (op_i == ALU_SRA);

   always_comb begin
      case (op_i)
         ALU_SUB:  comb_result = a_i - b_i;
         ALU_SLT,
         ALU_LT:   comb_result = {31'b0, $signed(a_i) < $signed(b_i)};
         ALU_SLTU,
         ALU_LTU:  comb_result = {31'b0, a_i < b_i};
         ALU_XOR:  comb_result = a_i ^ b_i;
         ALU_OR:   comb_result = a_i | b_i;
         ALU_AND:  comb_result = a_i & b_i;
         ALU_EQ:   comb_result = {31'b0, a_i == b_i};
         ALU_NE:   comb_result = {31'b0, a_i != b_i};
         ALU_GE:   comb_result = {31'b0, $signed(a_i) >= $signed(b_i)};
         ALU_GEU:  comb_result = {31'b0, a_i >= b_i};
         default:  comb_result = a_i + b_i;
      endcase
   end

   // One bit per cycle
   always_comb begin
      case (shift_op)
         ALU_SLL: shifted = {result_o[30:0], 1'b0};
         ALU_SRL: shifted = {1'b0, result_o[31:1]};
         default: shifted = {result_o[31], result_o[31:1]};
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         done_o <= 1'b0;
         busy   <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (start_i) begin
            busy   <= is_shift && (b_i[4:0] != 5'd0);
            done_o <= !is_shift || (b_i[4:0] == 5'd0);
         end else if (busy && count == 5'd1) begin
            busy   <= 1'b0;
            done_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start_i) begin
         result_o <= is_shift ? a_i : comb_result;
         count    <= b_i[4:0];
         shift_op <= op_i;
      end else if (busy) begin
         result_o <= shifted;
         count    <= count - 5'd1;
      end
   end

endmodule

`default_nettype wire

/* multicycle.sv */
`default_nettype none

module multicycle import rv_pkg::*; #(
   parameter xlen_t RESET_PC    = 32'h0000_0000,
   parameter xlen_t TRAP_VECTOR = 32'h0000_0100
) (
   input  wire logic   clk,
   input  wire logic   rst,
   output mem_op_t     mem_op_o,
   output xlen_t       mem_addr_o,
   output xlen_t       mem_wdata_o,
   input  wire xlen_t  mem_rdata_i,
   output xlen_t       pc_o,
   output logic        exception_o
);

   stage_t   stage_reg;
   stage_t   stage_next;
   xlen_t    pc_reg;
   xlen_t    pc_next;
   instr_u   fetch_word;
   logic     decode;
   xlen_t    imm;

   reg_idx_t rs1;
   reg_idx_t rs2;
   reg_idx_t rd;
   alu_op_t  ctl_alu_op;
   logic     ctl_from_pc;
   logic     ctl_from_imm;
   logic     ctl_reg_write;
   wb_sel_t  ctl_wb_sel;
   mem_op_t  ctl_mem_op;
   logic     ctl_is_jal;
   logic     ctl_is_jalr;
   logic     ctl_is_branch;
   logic     ctl_invalid;

   logic     rf_we;
   xlen_t    rf_wdata;
   xlen_t    rdata1;
   xlen_t    rdata2;

   alu_op_t  alu_op;
   xlen_t    alu_a;
   xlen_t    alu_b;
   logic     alu_start;
   logic     alu_done;
   xlen_t    alu_result;
   xlen_t    jump_target;
   logic     data_misaligned;

   assign pc_o       = pc_reg;
   assign fetch_word = mem_rdata_i;

   instr_decoder u_dec (
      .clk,
      .store_i    (decode),
      .raw_i      (mem_rdata_i),
      .instr_o    (),
      .imm_o      (imm),
      .imm_next_o ()
   );

   control_unit u_ctl (
      .clk,
      .decode_i       (decode),
      .instr_i        (fetch_word),
      .rs1_o          (rs1),
      .rs2_o          (rs2),
      .rd_o           (rd),
      .alu_op_o       (ctl_alu_op),
      .alu_from_pc_o  (ctl_from_pc),
      .alu_from_imm_o (ctl_from_imm),
      .reg_write_o    (ctl_reg_write),
      .wb_sel_o       (ctl_wb_sel),
      .mem_op_o       (ctl_mem_op),
      .is_jal_o       (ctl_is_jal),
      .is_jalr_o      (ctl_is_jalr),
      .is_branch_o    (ctl_is_branch),
      .invalid_o      (ctl_invalid)
   );

   reg_file u_rf (
      .clk,
      .rs1_i    (rs1),
      .rs2_i    (rs2),
      .rd_i     (rd),
      .we_i     (rf_we),
      .wdata_i  (rf_wdata),
      .rdata1_o (rdata1),
      .rdata2_o (rdata2)
   );

   alu u_alu (
      .clk,
      .rst,
      .start_i  (alu_start),
      .op_i     (alu_op),
      .a_i      (alu_a),
      .b_i      (alu_b),
      .done_o   (alu_done),
      .result_o (alu_result)
   );

   ////////////////////////////////////////////////////////////
   // Trap detection and writeback source
   ////////////////////////////////////////////////////////////

   assign data_misaligned = (ctl_mem_op != MEM_NOP) && (alu_result[1:0] != 2'b00);
   assign jump_target     = ctl_is_jalr ? {alu_result[31:1], 1'b0} : alu_result;

   always_comb begin
      case (ctl_wb_sel)
         WB_MEM:  rf_wdata = mem_rdata_i;
         WB_PC4:  rf_wdata = pc_reg + 32'd4;
         WB_IMM:  rf_wdata = imm;
         default: rf_wdata = alu_result;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         stage_reg <= PC_FETCH;
         pc_reg    <= RESET_PC;
      end else begin
         stage_reg <= stage_next;
         if (stage_next == PC_FETCH) begin
            pc_reg <= pc_next;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Stage FSM
   ////////////////////////////////////////////////////////////

   always_comb begin
      stage_next  = stage_reg;
      pc_next     = pc_reg;
      mem_op_o    = MEM_NOP;
      mem_addr_o  = '0;
      mem_wdata_o = '0;
      alu_op      = ALU_ADD;
      alu_a       = '0;
      alu_b       = '0;
      alu_start   = 1'b0;
      rf_we       = 1'b0;
      decode      = 1'b0;
      exception_o = 1'b0;
      case (stage_reg)
         PC_FETCH: begin
            mem_addr_o = pc_reg;
            mem_op_o   = MEM_LW;
            stage_next = INST_DEC;
         end
         INST_DEC: begin
            mem_addr_o = pc_reg;
            mem_op_o   = MEM_LW;
            decode     = 1'b1;
            stage_next = READ_REGS;
         end
         READ_REGS: begin
            stage_next = ctl_invalid ? CALC_NEXT_PC : ALU_START;
         end
         ALU_START: begin
            alu_op     = ctl_alu_op;
            alu_a      = ctl_from_pc ? pc_reg : rdata1;
            alu_b      = ctl_from_imm ? imm : rdata2;
            alu_start  = 1'b1;
            stage_next = WAIT_ALU;
         end
         WAIT_ALU: begin
            if (alu_done) begin
               stage_next = MEM_OP;
            end
         end
         MEM_OP: begin
            mem_addr_o  = alu_result;
            mem_wdata_o = rdata2;
            if (data_misaligned) begin
               exception_o = 1'b1;
            end else begin
               mem_op_o   = ctl_mem_op;
               stage_next = ctl_reg_write ? WRITEBACK : CALC_NEXT_PC;
            end
         end
         WRITEBACK: begin
            rf_we      = 1'b1;
            stage_next = CALC_NEXT_PC;
         end
         CALC_NEXT_PC: begin
            if (ctl_invalid) begin
               exception_o = 1'b1;
            end else if (ctl_is_jal || ctl_is_jalr) begin
               exception_o = jump_target[1];
               pc_next     = jump_target;
               stage_next  = PC_FETCH;
            end else if (ctl_is_branch && alu_result[0]) begin
               // PC is aligned, so only the offset can misalign the target
               exception_o = imm[1];
               alu_a       = pc_reg;
               alu_b       = imm;
               alu_start   = !imm[1];
               stage_next  = WAIT_ALU_PC;
            end else begin
               alu_a      = pc_reg;
               alu_b      = 32'd4;
               alu_start  = 1'b1;
               stage_next = WAIT_ALU_PC;
            end
         end
         WAIT_ALU_PC: begin
            if (alu_done) begin
               stage_next = STORE_ALU_PC;
            end
         end
         STORE_ALU_PC: begin
            pc_next    = alu_result;
            stage_next = PC_FETCH;
         end
         default: stage_next = PC_FETCH;
      endcase
      if (exception_o) begin
         pc_next    = TRAP_VECTOR;
         stage_next = PC_FETCH;
      end
   end

endmodule

`default_nettype wire

/* unified_mem.sv */
`default_nettype none

module unified_mem import rv_pkg::*; #(
   parameter int MEM_WORDS = 1024
) (
   input  wire logic  clk,
   input  wire logic  we_i,
   input  wire xlen_t addr_i,
   input  wire xlen_t wdata_i,
   output xlen_t      rdata_o
);

   localparam int AW = $clog2(MEM_WORDS);

   xlen_t         mem [MEM_WORDS];
   logic [AW-1:0] idx;

   // Word index wraps at the array size
   assign idx = AW'(addr_i[31:2] % MEM_WORDS);

   // Read returns the contents before a same-cycle write
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[idx] <= wdata_i;
      end
      rdata_o <= mem[idx];
   end

endmodule

`default_nettype wire

/* rv_top.sv */
`default_nettype none

module rv_top import rv_pkg::*; #(
   parameter xlen_t RESET_PC    = 32'h0000_0000,
   parameter xlen_t TRAP_VECTOR = 32'h0000_0100,
   parameter int    MEM_WORDS   = 1024
) (
   input  wire logic  clk,
   input  wire logic  rst,
   input  wire logic  run_i,
   input  wire logic  load_we_i,
   input  wire xlen_t load_addr_i,
   input  wire xlen_t load_wdata_i,
   output xlen_t      load_rdata_o,
   output xlen_t      pc_o,
   output logic       exception_o
);

   logic    core_rst;
   mem_op_t core_op;
   xlen_t   core_addr;
   xlen_t   core_wdata;
   logic    mem_we;
   xlen_t   mem_addr;
   xlen_t   mem_wdata;
   xlen_t   mem_rdata;

   // Core stays in reset while the host owns the memory
   assign core_rst = rst || !run_i;

   assign mem_we       = run_i ? (core_op == MEM_SW) : load_we_i;
   assign mem_addr     = run_i ? core_addr : load_addr_i;
   assign mem_wdata    = run_i ? core_wdata : load_wdata_i;
   assign load_rdata_o = mem_rdata;

   multicycle #(
      .RESET_PC    (RESET_PC),
      .TRAP_VECTOR (TRAP_VECTOR)
   ) u_core (
      .clk,
      .rst         (core_rst),
      .mem_op_o    (core_op),
      .mem_addr_o  (core_addr),
      .mem_wdata_o (core_wdata),
      .mem_rdata_i (mem_rdata),
      .pc_o,
      .exception_o
   );

   unified_mem #(
      .MEM_WORDS (MEM_WORDS)
   ) u_mem (
      .clk,
      .we_i    (mem_we),
      .addr_i  (mem_addr),
      .wdata_i (mem_wdata),
      .rdata_o (mem_rdata)
   );

endmodule

`default_nettype wire

/* tb_rv_assertions.sv */
`default_nettype none

module tb_rv_assertions import rv_pkg::*; (
   input wire logic    clk,
   input wire logic    rst,
   input wire mem_op_t mem_op_o,
   input wire xlen_t   mem_addr_o,
   input wire xlen_t   pc_o,
   input wire logic    exception_o
);

   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;

   pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_o[1:0] == 2'b00)
      else begin
         $error("PC not word aligned: %h", pc_o);
         fail_count++;
      end

   // A trapped store must not reach the memory
   no_store_on_trap: assert property (@(posedge clk) disable iff (rst)
      !(exception_o && mem_op_o == MEM_SW))
      else begin
         $error("Store issued while a trap is taken");
         fail_count++;
      end

   quiet_in_reset: assert property (@(posedge clk) rst |-> !exception_o)
      else begin
         $error("Exception raised during reset");
         fail_count++;
      end

   store_aligned: assert property (@(posedge clk) disable iff (rst)
      mem_op_o == MEM_SW |-> mem_addr_o[1:0] == 2'b00)
      else begin
         $error("Store to misaligned address %h", mem_addr_o);
         fail_count++;
      end

endmodule

bind multicycle tb_rv_assertions u_assertions (.*);

`default_nettype wire

/* tb_rv_top.sv */
`default_nettype none

module tb_rv_top import rv_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam xlen_t TRAP = 32'h0000_0100;
   localparam xlen_t DATA = 32'h0000_0200;

   logic  clk = 1'b0;
   logic  rst;
   logic  run_i;
   logic  load_we_i;
   xlen_t load_addr_i;
   xlen_t load_wdata_i;
   xlen_t load_rdata_o;
   xlen_t pc_o;
   logic  exception_o;
   xlen_t prog [$];
   int    cycles = 0;

   rv_top #(
      .TRAP_VECTOR (TRAP)
   ) u_rv_top (
      .clk,
      .rst,
      .run_i,
      .load_we_i,
      .load_addr_i,
      .load_wdata_i,
      .load_rdata_o,
      .pc_o,
      .exception_o
   );

   always #10 clk = ~clk;

   // About 1800 cycles needed for all programs
   always @(posedge clk) begin
      cycles++;
      if (cycles == 4000) begin
         $display("Timeout: no halt reached within %0d cycles", cycles);
         $display("TB FAILED");
         $fatal(1);
      end
   end

   ////////////////////////////////////////////////////////////
   // Instruction assembly
   ////////////////////////////////////////////////////////////

   function automatic xlen_t r_type(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                    reg_idx_t rs1, reg_idx_t rs2);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic xlen_t i_type(logic [6:0] op, logic [2:0] f3, reg_idx_t rd,
                                    reg_idx_t rs1, logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic xlen_t s_type(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
   endfunction

   function automatic xlen_t b_type(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                    logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
   endfunction

   function automatic xlen_t u_type(logic [6:0] op, reg_idx_t rd, logic [19:0] imm);
      return {imm, rd, op};
   endfunction

   function automatic xlen_t j_type(reg_idx_t rd, logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
   endfunction

   function automatic logic branch_taken(logic [2:0] f3, xlen_t a, xlen_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic xlen_t next_pc();
      return xlen_t'(prog.size() * 4);
   endfunction

   ////////////////////////////////////////////////////////////
   // Drivers and checks
   ////////////////////////////////////////////////////////////

   task automatic check_word(string name, xlen_t got, xlen_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("TB FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         $display("TB FAILED");
         $fatal(1);
      end
   endtask

   task automatic load_word(xlen_t addr, xlen_t data);
      @(negedge clk);
      load_we_i    = 1'b1;
      load_addr_i  = addr;
      load_wdata_i = data;
      @(negedge clk);
      load_we_i = 1'b0;
   endtask

   task automatic expect_word(xlen_t addr, xlen_t exp);
      @(negedge clk);
      load_addr_i = addr;
      @(negedge clk);
      check_word($sformatf("word 0x%0h", addr), load_rdata_o, exp);
   endtask

   task automatic emit(xlen_t word);
      prog.push_back(word);
   endtask

   task automatic load_program();
      foreach (prog[i]) begin
         load_word(xlen_t'(i * 4), prog[i]);
      end
      prog.delete();
   endtask

   // Halt is seen when pc_o holds the self-loop address for 20 cycles
   task automatic run_until_pc(xlen_t halt, output logic exc_seen, output logic trap_seen);
      int stable;
      stable    = 0;
      exc_seen  = 1'b0;
      trap_seen = 1'b0;
      @(negedge clk);
      run_i = 1'b1;
      while (stable < 20) begin
         @(negedge clk);
         if (exception_o) exc_seen = 1'b1;
         if (pc_o == TRAP) trap_seen = 1'b1;
         stable = (pc_o == halt) ? stable + 1 : 0;
      end
      run_i = 1'b0;
   endtask

   task automatic finish_program(output logic exc, output logic trap);
      xlen_t halt;
      halt = next_pc();
      emit(j_type(5'd0, 21'd0));
      load_program();
      run_until_pc(halt, exc, trap);
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic test_alu();
      logic [6:0]  f7s [7] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00};
      logic [2:0]  f3s [7] = '{3'd0, 3'd0, 3'd4, 3'd6, 3'd7, 3'd2, 3'd3};
      xlen_t       exp [8];
      xlen_t       a;
      xlen_t       b;
      logic [11:0] imm;
      logic        exc;
      logic        trap;
      a   = $urandom;
      b   = $urandom;
      imm = 12'($urandom);
      load_word(DATA, a);
      load_word(DATA + 32'd4, b);
      emit(i_type(OP_IMM, 3'd0, 5'd1, 5'd0, 12'h200));
      emit(i_type(OP_LOAD, 3'd2, 5'd2, 5'd1, 12'h000));
      emit(i_type(OP_LOAD, 3'd2, 5'd3, 5'd1, 12'h004));
      emit(i_type(OP_IMM, 3'd0, 5'd4, 5'd2, imm));
      emit(s_type(5'd4, 5'd1, 12'h100));
      for (int k = 0; k < 7; k++) begin
         emit(r_type(f7s[k], f3s[k], 5'd4, 5'd2, 5'd3));
         emit(s_type(5'd4, 5'd1, 12'(32'h104 + 4 * k)));
      end
      finish_program(exc, trap);
      check_flag("exception_o", exc, 1'b0);
      exp[0] = a + {{20{imm[11]}}, imm};
      exp[1] = a + b;
      exp[2] = a - b;
      exp[3] = a ^ b;
      exp[4] = a | b;
      exp[5] = a & b;
      exp[6] = {31'b0, $signed(a) < $signed(b)};
      exp[7] = {31'b0, a < b};
      for (int k = 0; k < 8; k++) begin
         expect_word(DATA + 32'h100 + xlen_t'(4 * k), exp[k]);
      end
   endtask

   task automatic test_shifts();
      logic [4:0] amt [4];
      logic [2:0] f3s [3] = '{3'd1, 3'd5, 3'd5};
      logic [6:0] f7s [3] = '{7'h00, 7'h00, 7'h20};
      xlen_t      a;
      logic       exc;
      logic       trap;
      a = $urandom | 32'h8000_0000;
      foreach (amt[k]) amt[k] = 5'($urandom);
      load_word(DATA, a);
      emit(i_type(OP_IMM, 3'd0, 5'd1, 5'd0, 12'h200));
      emit(i_type(OP_LOAD, 3'd2, 5'd2, 5'd1, 12'h000));
      for (int k = 0; k < 3; k++) begin
         emit(i_type(OP_IMM, 3'd0, 5'd3, 5'd0, {7'd0, amt[k]}));
         emit(r_type(f7s[k], f3s[k], 5'd4, 5'd2, 5'd3));
         emit(s_type(5'd4, 5'd1, 12'(32'h100 + 4 * k)));
      end
      // SRAI carries funct7 in the immediate
      emit(i_type(OP_IMM, 3'd5, 5'd4, 5'd2, {7'h20, amt[3]}));
      emit(s_type(5'd4, 5'd1, 12'h10C));
      finish_program(exc, trap);
      check_flag("exception_o", exc, 1'b0);
      expect_word(DATA + 32'h100, a << amt[0]);
      expect_word(DATA + 32'h104, a >> amt[1]);
      expect_word(DATA + 32'h108, $signed(a) >>> amt[2]);
      expect_word(DATA + 32'h10C, $signed(a) >>> amt[3]);
   endtask

   task automatic test_mem_upper();
      xlen_t       w [4];
      logic [19:0] up_lui;
      logic [19:0] up_auipc;
      xlen_t       auipc_pc;
      logic        exc;
      logic        trap;
      up_lui   = 20'($urandom);
      up_auipc = 20'($urandom);
      emit(i_type(OP_IMM, 3'd0, 5'd1, 5'd0, 12'h200));
      for (int k = 0; k < 4; k++) begin
         w[k] = $urandom;
         load_word(DATA + xlen_t'(4 * k), w[k]);
         emit(i_type(OP_LOAD, 3'd2, 5'd2, 5'd1, 12'(4 * k)));
         emit(s_type(5'd2, 5'd1, 12'(32'h100 + 4 * k)));
      end
      emit(u_type(OP_LUI, 5'd4, up_lui));
      emit(s_type(5'd4, 5'd1, 12'h110));
      auipc_pc = next_pc();
      emit(u_type(OP_AUIPC, 5'd4, up_auipc));
      emit(s_type(5'd4, 5'd1, 12'h114));
      finish_program(exc, trap);
      check_flag("exception_o", exc, 1'b0);
      for (int k = 0; k < 4; k++) begin
         expect_word(DATA + 32'h100 + xlen_t'(4 * k), w[k]);
      end
      expect_word(DATA + 32'h110, {up_lui, 12'b0});
      expect_word(DATA + 32'h114, auipc_pc + {up_auipc, 12'b0});
   endtask

   task automatic test_branches();
      logic [2:0] f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      reg_idx_t   rs1s [12] = '{5'd2, 5'd2, 5'd2, 5'd2, 5'd3, 5'd2,
                                5'd2, 5'd3, 5'd2, 5'd3, 5'd3, 5'd2};
      reg_idx_t   rs2s [12] = '{5'd5, 5'd3, 5'd3, 5'd5, 5'd2, 5'd3,
                                5'd3, 5'd2, 5'd3, 5'd2, 5'd2, 5'd3};
      xlen_t      rv [8];
      xlen_t      jal_pc;
      xlen_t      jalr_pc;
      logic       exc;
      logic       trap;
      rv[2] = 32'd5;
      rv[3] = 32'hFFFF_FFFD;
      rv[5] = 32'd5;
      emit(i_type(OP_IMM, 3'd0, 5'd1, 5'd0, 12'h200));
      emit(i_type(OP_IMM, 3'd0, 5'd2, 5'd0, 12'd5));
      emit(i_type(OP_IMM, 3'd0, 5'd3, 5'd0, 12'hFFD));
      emit(i_type(OP_IMM, 3'd0, 5'd5, 5'd0, 12'd5));
      // Taken branch skips the not-taken marker
      for (int k = 0; k < 12; k++) begin
         emit(i_type(OP_IMM, 3'd0, 5'd4, 5'd0, 12'(32'h100 + k)));
         emit(b_type(f3s[k / 2], rs1s[k], rs2s[k], 13'd8));
         emit(i_type(OP_IMM, 3'd0, 5'd4, 5'd0, 12'(32'h200 + k)));
         emit(s_type(5'd4, 5'd1, 12'(32'h100 + 4 * k)));
      end
      // A missed jump overwrites the link register
      jal_pc = next_pc();
      emit(j_type(5'd6, 21'd8));
      emit(i_type(OP_IMM, 3'd0, 5'd6, 5'd0, 12'h7FF));
      emit(s_type(5'd6, 5'd1, 12'h130));
      jalr_pc = next_pc() + 32'd4;
      emit(i_type(OP_IMM, 3'd0, 5'd7, 5'd0, 12'(jalr_pc + 32'd8)));
      emit(i_type(OP_JALR, 3'd0, 5'd8, 5'd7, 12'h000));
      emit(i_type(OP_IMM, 3'd0, 5'd8, 5'd0, 12'h7FF));
      emit(s_type(5'd8, 5'd1, 12'h134));
      finish_program(exc, trap);
      check_flag("exception_o", exc, 1'b0);
      for (int k = 0; k < 12; k++) begin
         expect_word(DATA + 32'h100 + xlen_t'(4 * k),
                     branch_taken(f3s[k / 2], rv[rs1s[k]], rv[rs2s[k]]) ?
                     32'h100 + xlen_t'(k) : 32'h200 + xlen_t'(k));
      end
      expect_word(DATA + 32'h130, jal_pc + 32'd4);
      expect_word(DATA + 32'h134, jalr_pc + 32'd4);
   endtask

   // Handler at the trap vector stores x9, then halts
   task automatic run_trap(xlen_t bad, logic [11:0] marker);
      logic exc;
      logic trap;
      load_word(TRAP, s_type(5'd9, 5'd1, 12'h084));
      load_word(TRAP + 32'd4, j_type(5'd0, 21'd0));
      emit(i_type(OP_IMM, 3'd0, 5'd1, 5'd0, 12'h200));
      emit(i_type(OP_IMM, 3'd0, 5'd9, 5'd0, marker));
      emit(bad);
      load_program();
      run_until_pc(TRAP + 32'd4, exc, trap);
      check_flag("exception_o", exc, 1'b1);
      check_flag("pc_o at trap vector", trap, 1'b1);
      expect_word(DATA + 32'h084, {20'd0, marker});
   endtask

   task automatic test_traps();
      xlen_t sentinel;
      sentinel = $urandom;
      load_word(DATA + 32'h088, sentinel);
      run_trap(i_type(OP_LOAD, 3'd2, 5'd9, 5'd1, 12'h002), 12'h055);
      run_trap(s_type(5'd9, 5'd1, 12'h089), 12'h066);
      expect_word(DATA + 32'h088, sentinel);
      run_trap(32'hFFFF_FFFF, 12'h077);
   endtask

   initial begin
      rst          = 1'b1;
      run_i        = 1'b0;
      load_we_i    = 1'b0;
      load_addr_i  = '0;
      load_wdata_i = '0;
      void'($urandom(68));
      repeat (4) @(negedge clk);
      rst = 1'b0;
      test_alu();
      test_shifts();
      test_mem_upper();
      test_branches();
      test_traps();
      if (u_rv_top.u_core.u_assertions.fail_count == 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         $display("TB FAILED");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

/* build.f */
rv_pkg.sv
instr_decoder.sv
control_unit.sv
reg_file.sv
alu.sv
multicycle.sv
unified_mem.sv
rv_top.sv
tb_rv_assertions.sv
tb_rv_top.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module tb_rv_top -o sim_tb; then
   echo "Verilator compile failed"
   exit 1
fi

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
   cat sim.log
   echo "Simulation exited with an error"
   exit 1
fi

cat sim.log
if grep -q "TB PASSED" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
